/* hdl/lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

	localparam int word_width = 16;
	localparam int reg_count = 8;
	localparam int reg_idx_width = 3;

	// LC-3b encodings, only the four kept opcodes
	typedef enum logic [3:0]
	{
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	// Instruction field positions
	localparam int op_msb = 15;
	localparam int op_lsb = 12;
	localparam int dest_msb = 11;
	localparam int dest_lsb = 9;
	localparam int sr1_msb = 8;
	localparam int sr1_lsb = 6;
	localparam int sr2_msb = 2;
	localparam int sr2_lsb = 0;
	localparam int imm_flag_bit = 5; // Set for imm5 form
	localparam int imm5_msb = 4;
	localparam int imm5_lsb = 0;
	localparam int off9_msb = 8;
	localparam int off9_lsb = 0;

endpackage

/* hdl/ooo_pkg.sv */
package ooo_pkg;

	// Reorder buffer
	localparam int rob_depth = 4;
	localparam int tag_width = 2; // Tag is the ROB index
	localparam int count_width = 3; // Holds 0 to rob_depth

	// Reservation stations
	localparam int station_count = 2;

	typedef enum logic [1:0]
	{
		st_free,
		st_wait, // At least one operand pending on the CDB
		st_ready
	} station_state;

endpackage

/* hdl/issue_control.sv */
module issue_control
(
	input logic [lc3b_isa_pkg::word_width-1:0] instr,
	input logic [lc3b_isa_pkg::word_width-1:0] instr_pc,
	input logic instr_valid,
	input logic rob_full,
	input logic [ooo_pkg::tag_width-1:0] rob_tail,
	input logic [ooo_pkg::station_count-1:0] station_busy,
	input logic sr1_busy,
	input logic [ooo_pkg::tag_width-1:0] sr1_tag,
	input logic [lc3b_isa_pkg::word_width-1:0] sr1_value,
	input logic sr2_busy,
	input logic [ooo_pkg::tag_width-1:0] sr2_tag,
	input logic [lc3b_isa_pkg::word_width-1:0] sr2_value,
	input logic rob_j_done,
	input logic [lc3b_isa_pkg::word_width-1:0] rob_j_value,
	input logic rob_k_done,
	input logic [lc3b_isa_pkg::word_width-1:0] rob_k_value,
	input logic cdb_valid,
	input logic [ooo_pkg::tag_width-1:0] cdb_tag,
	input logic [lc3b_isa_pkg::word_width-1:0] cdb_value,
	output logic instr_ready,
	output logic [lc3b_isa_pkg::reg_idx_width-1:0] sr1,
	output logic [lc3b_isa_pkg::reg_idx_width-1:0] sr2,
	output logic [ooo_pkg::station_count-1:0] rs_write,
	output lc3b_isa_pkg::lc3b_opcode rs_op,
	output logic [lc3b_isa_pkg::word_width-1:0] rs_vj,
	output logic [ooo_pkg::tag_width-1:0] rs_qj,
	output logic rs_j_ready,
	output logic [lc3b_isa_pkg::word_width-1:0] rs_vk,
	output logic [ooo_pkg::tag_width-1:0] rs_qk,
	output logic rs_k_ready,
	output logic [ooo_pkg::tag_width-1:0] rs_tag,
	output logic rob_alloc,
	output logic [lc3b_isa_pkg::reg_idx_width-1:0] rob_dest,
	output logic [lc3b_isa_pkg::word_width-1:0] rob_value,
	output logic rob_done,
	output logic reg_claim,
	output logic [lc3b_isa_pkg::reg_idx_width-1:0] reg_dest,
	output logic [ooo_pkg::tag_width-1:0] reg_tag
);
	lc3b_isa_pkg::lc3b_opcode opcode;
	logic is_alu;
	logic accept;
	logic [ooo_pkg::station_count-1:0] free_onehot;
	logic [lc3b_isa_pkg::word_width-1:0] imm5_sext;
	logic [lc3b_isa_pkg::word_width-1:0] off9_sext;

	assign opcode = lc3b_isa_pkg::lc3b_opcode'(instr[lc3b_isa_pkg::op_msb:lc3b_isa_pkg::op_lsb]);
	assign is_alu = (opcode != lc3b_isa_pkg::op_lea);
	assign sr1 = instr[lc3b_isa_pkg::sr1_msb:lc3b_isa_pkg::sr1_lsb];
	assign sr2 = instr[lc3b_isa_pkg::sr2_msb:lc3b_isa_pkg::sr2_lsb];

	assign imm5_sext = {{(lc3b_isa_pkg::word_width - lc3b_isa_pkg::imm5_msb - 1)
		{instr[lc3b_isa_pkg::imm5_msb]}}, instr[lc3b_isa_pkg::imm5_msb:lc3b_isa_pkg::imm5_lsb]};
	assign off9_sext = {{(lc3b_isa_pkg::word_width - lc3b_isa_pkg::off9_msb - 1)
		{instr[lc3b_isa_pkg::off9_msb]}}, instr[lc3b_isa_pkg::off9_msb:lc3b_isa_pkg::off9_lsb]};

	// Lowest clear bit of the busy vector, zero when all busy
	assign free_onehot = ~station_busy & (station_busy + 1'b1);

	assign instr_ready = !rob_full && (!is_alu || (|free_onehot));
	assign accept = instr_valid && instr_ready;

	assign rs_write = (accept && is_alu) ? free_onehot : '0;
	assign rs_op = opcode;
	assign rs_tag = rob_tail;

	// Operand J from sr1
	always_comb
	begin
		rs_vj = sr1_value;
		rs_qj = sr1_tag;
		rs_j_ready = 1'b1;
		if (sr1_busy)
		begin
			if (cdb_valid && cdb_tag == sr1_tag)
				rs_vj = cdb_value; // Result broadcast this cycle
			else if (rob_j_done)
				rs_vj = rob_j_value;
			else
				rs_j_ready = 1'b0;
		end
	end

	// Operand K from sr2, imm5 or the NOT mask
	always_comb
	begin
		rs_vk = sr2_value;
		rs_qk = sr2_tag;
		rs_k_ready = 1'b1;
		if (opcode == lc3b_isa_pkg::op_not)
			rs_vk = '1;
		else if (instr[lc3b_isa_pkg::imm_flag_bit])
			rs_vk = imm5_sext;
		else if (sr2_busy)
		begin
			if (cdb_valid && cdb_tag == sr2_tag)
				rs_vk = cdb_value;
			else if (rob_k_done)
				rs_vk = rob_k_value;
			else
				rs_k_ready = 1'b0;
		end
	end

	assign rob_alloc = accept;
	assign rob_dest = instr[lc3b_isa_pkg::dest_msb:lc3b_isa_pkg::dest_lsb];
	assign rob_value = instr_pc + {off9_sext[lc3b_isa_pkg::word_width-2:0], 1'b0}; // LEA target
	assign rob_done = !is_alu; // LEA completes at issue

	assign reg_claim = accept;
	assign reg_dest = instr[lc3b_isa_pkg::dest_msb:lc3b_isa_pkg::dest_lsb];
	assign reg_tag = rob_tail;

endmodule

/* hdl/alu_station.sv */
module alu_station
(
	input logic clk,
	input logic rst,
	input logic [ooo_pkg::station_count-1:0] rs_write,
	input lc3b_isa_pkg::lc3b_opcode rs_op,
	input logic [lc3b_isa_pkg::word_width-1:0] rs_vj,
	input logic [ooo_pkg::tag_width-1:0] rs_qj,
	input logic rs_j_ready,
	input logic [lc3b_isa_pkg::word_width-1:0] rs_vk,
	input logic [ooo_pkg::tag_width-1:0] rs_qk,
	input logic rs_k_ready,
	input logic [ooo_pkg::tag_width-1:0] rs_tag,
	output logic [ooo_pkg::station_count-1:0] station_busy,
	output logic cdb_valid,
	output logic [ooo_pkg::tag_width-1:0] cdb_tag,
	output logic [lc3b_isa_pkg::word_width-1:0] cdb_value
);
	ooo_pkg::station_state state [ooo_pkg::station_count];
	lc3b_isa_pkg::lc3b_opcode op [ooo_pkg::station_count];
	logic [lc3b_isa_pkg::word_width-1:0] vj [ooo_pkg::station_count];
	logic [lc3b_isa_pkg::word_width-1:0] vk [ooo_pkg::station_count];
	logic [ooo_pkg::tag_width-1:0] qj [ooo_pkg::station_count];
	logic [ooo_pkg::tag_width-1:0] qk [ooo_pkg::station_count];
	logic [ooo_pkg::tag_width-1:0] dest [ooo_pkg::station_count];
	logic [ooo_pkg::station_count-1:0] j_ok;
	logic [ooo_pkg::station_count-1:0] k_ok;
	logic [ooo_pkg::station_count-1:0] j_hit;
	logic [ooo_pkg::station_count-1:0] k_hit;
	logic [ooo_pkg::station_count-1:0] ready_vec;
	logic [ooo_pkg::station_count-1:0] pick;
	lc3b_isa_pkg::lc3b_opcode alu_op;
	logic [lc3b_isa_pkg::word_width-1:0] alu_a;
	logic [lc3b_isa_pkg::word_width-1:0] alu_b;
	logic [lc3b_isa_pkg::word_width-1:0] alu_out;
	logic [ooo_pkg::tag_width-1:0] alu_tag;

	always_comb
	begin
		for (int i = 0; i < ooo_pkg::station_count; i++)
		begin
			station_busy[i] = (state[i] != ooo_pkg::st_free);
			ready_vec[i] = (state[i] == ooo_pkg::st_ready);
			j_hit[i] = !j_ok[i] && cdb_valid && (cdb_tag == qj[i]); // Snoop own bus
			k_hit[i] = !k_ok[i] && cdb_valid && (cdb_tag == qk[i]);
		end
	end

	assign pick = ready_vec & (~ready_vec + 1'b1); // Station 0 wins a tie

	always_comb
	begin
		alu_op = op[0];
		alu_a = vj[0];
		alu_b = vk[0];
		alu_tag = dest[0];
		for (int i = 1; i < ooo_pkg::station_count; i++)
		begin
			if (pick[i])
			begin
				alu_op = op[i];
				alu_a = vj[i];
				alu_b = vk[i];
				alu_tag = dest[i];
			end
		end
	end

	always_comb
	begin
		case (alu_op)
			lc3b_isa_pkg::op_and: alu_out = alu_a & alu_b;
			lc3b_isa_pkg::op_not: alu_out = alu_a ^ alu_b; // Vk is all ones
			default: alu_out = alu_a + alu_b; // ADD
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < ooo_pkg::station_count; i++)
				state[i] <= ooo_pkg::st_free;
			cdb_valid <= 1'b0;
		end
		else
		begin
			for (int i = 0; i < ooo_pkg::station_count; i++)
			begin
				if (rs_write[i])
					state[i] <= (rs_j_ready && rs_k_ready) ? ooo_pkg::st_ready : ooo_pkg::st_wait;
				else if (pick[i])
					state[i] <= ooo_pkg::st_free;
				else if (state[i] == ooo_pkg::st_wait && (j_ok[i] || j_hit[i]) && (k_ok[i] || k_hit[i]))
					state[i] <= ooo_pkg::st_ready;
			end
			cdb_valid <= |pick;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < ooo_pkg::station_count; i++)
		begin
			if (rs_write[i])
			begin
				op[i] <= rs_op;
				vj[i] <= rs_vj;
				vk[i] <= rs_vk;
				qj[i] <= rs_qj;
				qk[i] <= rs_qk;
				dest[i] <= rs_tag;
				j_ok[i] <= rs_j_ready;
				k_ok[i] <= rs_k_ready;
			end
			else
			begin
				if (j_hit[i])
				begin
					vj[i] <= cdb_value;
					j_ok[i] <= 1'b1;
				end
				if (k_hit[i])
				begin
					vk[i] <= cdb_value;
					k_ok[i] <= 1'b1;
				end
			end
		end
		cdb_tag <= alu_tag;
		cdb_value <= alu_out;
	end

endmodule

/* hdl/reorder_buffer.sv */
module reorder_buffer
(
	input logic clk,
	input logic rst,
	input logic rob_alloc,
	input logic [lc3b_isa_pkg::reg_idx_width-1:0] rob_dest,
	input logic [lc3b_isa_pkg::word_width-1:0] rob_value,
	input logic rob_done,
	input logic cdb_valid,
	input logic [ooo_pkg::tag_width-1:0] cdb_tag,
	input logic [lc3b_isa_pkg::word_width-1:0] cdb_value,
	input logic [ooo_pkg::tag_width-1:0] j_tag,
	input logic [ooo_pkg::tag_width-1:0] k_tag,
	output logic [ooo_pkg::tag_width-1:0] rob_tail,
	output logic rob_full,
	output logic rob_j_done,
	output logic [lc3b_isa_pkg::word_width-1:0] rob_j_value,
	output logic rob_k_done,
	output logic [lc3b_isa_pkg::word_width-1:0] rob_k_value,
	output logic commit_valid,
	output logic [lc3b_isa_pkg::reg_idx_width-1:0] commit_reg,
	output logic [lc3b_isa_pkg::word_width-1:0] commit_value,
	output logic [ooo_pkg::tag_width-1:0] commit_tag
);
	logic [ooo_pkg::rob_depth-1:0] done;
	logic [lc3b_isa_pkg::reg_idx_width-1:0] dest [ooo_pkg::rob_depth];
	logic [lc3b_isa_pkg::word_width-1:0] value [ooo_pkg::rob_depth];
	logic [ooo_pkg::tag_width-1:0] head;
	logic [ooo_pkg::tag_width-1:0] tail;
	logic [ooo_pkg::count_width-1:0] count;

	assign rob_tail = tail;
	assign rob_full = (count == ooo_pkg::rob_depth);

	// Operand lookups for issue
	assign rob_j_done = done[j_tag];
	assign rob_j_value = value[j_tag];
	assign rob_k_done = done[k_tag];
	assign rob_k_value = value[k_tag];

	// Head retires once it is done
	assign commit_valid = (count != '0) && done[head];
	assign commit_reg = dest[head];
	assign commit_value = value[head];
	assign commit_tag = head;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
		end
		else
		begin
			if (rob_alloc)
			begin
				tail <= tail + 1'b1;
				done[tail] <= rob_done;
			end
			if (cdb_valid)
				done[cdb_tag] <= 1'b1; // Never the tail entry, that one is free
			if (commit_valid)
				head <= head + 1'b1;
			case ({rob_alloc, commit_valid})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rob_alloc)
		begin
			dest[tail] <= rob_dest;
			value[tail] <= rob_value;
		end
		if (cdb_valid)
			value[cdb_tag] <= cdb_value;
	end

endmodule

/* hdl/register_file.sv */
module register_file
(
	input logic clk,
	input logic rst,
	input logic [lc3b_isa_pkg::reg_idx_width-1:0] sr1,
	input logic [lc3b_isa_pkg::reg_idx_width-1:0] sr2,
	input logic reg_claim,
	input logic [lc3b_isa_pkg::reg_idx_width-1:0] reg_dest,
	input logic [ooo_pkg::tag_width-1:0] reg_tag,
	input logic commit_valid,
	input logic [lc3b_isa_pkg::reg_idx_width-1:0] commit_reg,
	input logic [lc3b_isa_pkg::word_width-1:0] commit_value,
	input logic [ooo_pkg::tag_width-1:0] commit_tag,
	output logic sr1_busy,
	output logic [ooo_pkg::tag_width-1:0] sr1_tag,
	output logic [lc3b_isa_pkg::word_width-1:0] sr1_value,
	output logic sr2_busy,
	output logic [ooo_pkg::tag_width-1:0] sr2_tag,
	output logic [lc3b_isa_pkg::word_width-1:0] sr2_value
);
	logic [lc3b_isa_pkg::word_width-1:0] vals [lc3b_isa_pkg::reg_count];
	logic [ooo_pkg::tag_width-1:0] owner [lc3b_isa_pkg::reg_count];
	logic [lc3b_isa_pkg::reg_count-1:0] busy;
	logic release_ok;

	// Only the latest producer releases, and a same-cycle claim wins
	assign release_ok = commit_valid && (owner[commit_reg] == commit_tag)
		&& !(reg_claim && reg_dest == commit_reg);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < lc3b_isa_pkg::reg_count; i++)
			begin
				vals[i] <= '0;
				owner[i] <= '0;
			end
			busy <= '0;
		end
		else
		begin
			if (commit_valid)
				vals[commit_reg] <= commit_value;
			if (release_ok)
				busy[commit_reg] <= 1'b0;
			if (reg_claim)
			begin
				busy[reg_dest] <= 1'b1;
				owner[reg_dest] <= reg_tag;
			end
		end
	end

	assign sr1_busy = busy[sr1];
	assign sr1_tag = owner[sr1];
	assign sr1_value = vals[sr1];
	assign sr2_busy = busy[sr2];
	assign sr2_tag = owner[sr2];
	assign sr2_value = vals[sr2];

endmodule

/* hdl/ooo_core.sv */
module ooo_core
(
	input logic clk,
	input logic rst,
	input logic [lc3b_isa_pkg::word_width-1:0] instr,
	input logic [lc3b_isa_pkg::word_width-1:0] instr_pc,
	input logic instr_valid,
	output logic instr_ready,
	output logic commit_valid,
	output logic [lc3b_isa_pkg::reg_idx_width-1:0] commit_reg,
	output logic [lc3b_isa_pkg::word_width-1:0] commit_value
);
	// Issue to station
	logic [ooo_pkg::station_count-1:0] rs_write;
	lc3b_isa_pkg::lc3b_opcode rs_op;
	logic [lc3b_isa_pkg::word_width-1:0] rs_vj;
	logic [lc3b_isa_pkg::word_width-1:0] rs_vk;
	logic [ooo_pkg::tag_width-1:0] rs_qj;
	logic [ooo_pkg::tag_width-1:0] rs_qk;
	logic rs_j_ready;
	logic rs_k_ready;
	logic [ooo_pkg::tag_width-1:0] rs_tag;
	logic [ooo_pkg::station_count-1:0] station_busy;

	// Common data bus
	logic cdb_valid;
	logic [ooo_pkg::tag_width-1:0] cdb_tag;
	logic [lc3b_isa_pkg::word_width-1:0] cdb_value;

	// Issue and ROB
	logic rob_alloc;
	logic [lc3b_isa_pkg::reg_idx_width-1:0] rob_dest;
	logic [lc3b_isa_pkg::word_width-1:0] rob_value;
	logic rob_done;
	logic [ooo_pkg::tag_width-1:0] rob_tail;
	logic rob_full;
	logic rob_j_done;
	logic rob_k_done;
	logic [lc3b_isa_pkg::word_width-1:0] rob_j_value;
	logic [lc3b_isa_pkg::word_width-1:0] rob_k_value;
	logic [ooo_pkg::tag_width-1:0] commit_tag;

	// Register file ports
	logic [lc3b_isa_pkg::reg_idx_width-1:0] sr1;
	logic [lc3b_isa_pkg::reg_idx_width-1:0] sr2;
	logic sr1_busy;
	logic sr2_busy;
	logic [ooo_pkg::tag_width-1:0] sr1_tag;
	logic [ooo_pkg::tag_width-1:0] sr2_tag;
	logic [lc3b_isa_pkg::word_width-1:0] sr1_value;
	logic [lc3b_isa_pkg::word_width-1:0] sr2_value;
	logic reg_claim;
	logic [lc3b_isa_pkg::reg_idx_width-1:0] reg_dest;
	logic [ooo_pkg::tag_width-1:0] reg_tag;

	issue_control u_issue
	(
		.instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid),
		.rob_full(rob_full), .rob_tail(rob_tail), .station_busy(station_busy),
		.sr1_busy(sr1_busy), .sr1_tag(sr1_tag), .sr1_value(sr1_value),
		.sr2_busy(sr2_busy), .sr2_tag(sr2_tag), .sr2_value(sr2_value),
		.rob_j_done(rob_j_done), .rob_j_value(rob_j_value),
		.rob_k_done(rob_k_done), .rob_k_value(rob_k_value),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.instr_ready(instr_ready), .sr1(sr1), .sr2(sr2),
		.rs_write(rs_write), .rs_op(rs_op),
		.rs_vj(rs_vj), .rs_qj(rs_qj), .rs_j_ready(rs_j_ready),
		.rs_vk(rs_vk), .rs_qk(rs_qk), .rs_k_ready(rs_k_ready), .rs_tag(rs_tag),
		.rob_alloc(rob_alloc), .rob_dest(rob_dest), .rob_value(rob_value), .rob_done(rob_done),
		.reg_claim(reg_claim), .reg_dest(reg_dest), .reg_tag(reg_tag)
	);

	alu_station u_station
	(
		.clk(clk), .rst(rst),
		.rs_write(rs_write), .rs_op(rs_op),
		.rs_vj(rs_vj), .rs_qj(rs_qj), .rs_j_ready(rs_j_ready),
		.rs_vk(rs_vk), .rs_qk(rs_qk), .rs_k_ready(rs_k_ready), .rs_tag(rs_tag),
		.station_busy(station_busy),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
	);

	reorder_buffer u_rob
	(
		.clk(clk), .rst(rst),
		.rob_alloc(rob_alloc), .rob_dest(rob_dest), .rob_value(rob_value), .rob_done(rob_done),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.j_tag(sr1_tag), .k_tag(sr2_tag), // Lookups follow the register tags
		.rob_tail(rob_tail), .rob_full(rob_full),
		.rob_j_done(rob_j_done), .rob_j_value(rob_j_value),
		.rob_k_done(rob_k_done), .rob_k_value(rob_k_value),
		.commit_valid(commit_valid), .commit_reg(commit_reg),
		.commit_value(commit_value), .commit_tag(commit_tag)
	);

	register_file u_regs
	(
		.clk(clk), .rst(rst), .sr1(sr1), .sr2(sr2),
		.reg_claim(reg_claim), .reg_dest(reg_dest), .reg_tag(reg_tag),
		.commit_valid(commit_valid), .commit_reg(commit_reg),
		.commit_value(commit_value), .commit_tag(commit_tag),
		.sr1_busy(sr1_busy), .sr1_tag(sr1_tag), .sr1_value(sr1_value),
		.sr2_busy(sr2_busy), .sr2_tag(sr2_tag), .sr2_value(sr2_value)
	);

endmodule

/* tests/ooo_core_chk.sv */
module ooo_core_chk
(
	input logic clk,
	input logic rst,
	input logic [lc3b_isa_pkg::word_width-1:0] instr,
	input logic [lc3b_isa_pkg::word_width-1:0] instr_pc,
	input logic instr_valid,
	input logic instr_ready,
	input logic commit_valid,
	input logic [ooo_pkg::count_width-1:0] rob_count,
	input ooo_pkg::station_state station0,
	input ooo_pkg::station_state station1
);
	// Ready station leaves st_ready within station_count edges
	property served(st);
		@(posedge clk) disable iff (rst)
			st == ooo_pkg::st_ready |-> ##[1:ooo_pkg::station_count] st != ooo_pkg::st_ready;
	endproperty

	assert property (@(posedge clk) disable iff (rst)
		instr_valid && !instr_ready |=> instr_valid && $stable(instr) && $stable(instr_pc))
		else $error("instruction changed while stalled");

	assert property (@(posedge clk) $fell(rst) |-> !commit_valid)
		else $error("commit in the first cycle after reset");

	assert property (@(posedge clk) disable iff (rst) rob_count <= ooo_pkg::rob_depth)
		else $error("reorder buffer count above depth");

	assert property (served(station0)) else $error("station 0 left unserved");
	assert property (served(station1)) else $error("station 1 left unserved");

endmodule

bind ooo_core ooo_core_chk u_chk
(
	.clk(clk), .rst(rst), .instr(instr), .instr_pc(instr_pc),
	.instr_valid(instr_valid), .instr_ready(instr_ready), .commit_valid(commit_valid),
	.rob_count(u_rob.count), // Internal state of the buffer
	.station0(u_station.state[0]), .station1(u_station.state[1])
);

/* tests/ooo_core_tb.sv */
module ooo_core_tb;

	localparam int n_instr = 400;
	localparam int cycle_limit = n_instr * 8 + 100;

	logic clk;
	logic rst;
	logic [lc3b_isa_pkg::word_width-1:0] instr;
	logic [lc3b_isa_pkg::word_width-1:0] instr_pc;
	logic instr_valid;
	logic instr_ready;
	logic commit_valid;
	logic [lc3b_isa_pkg::reg_idx_width-1:0] commit_reg;
	logic [lc3b_isa_pkg::word_width-1:0] commit_value;

	// Sequential reference state
	logic [lc3b_isa_pkg::word_width-1:0] model_regs [lc3b_isa_pkg::reg_count];
	logic [lc3b_isa_pkg::reg_idx_width-1:0] exp_reg [$];
	logic [lc3b_isa_pkg::word_width-1:0] exp_value [$];
	int cycles;

	ooo_core uut
	(
		.clk(clk), .rst(rst), .instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid),
		.instr_ready(instr_ready), .commit_valid(commit_valid),
		.commit_reg(commit_reg), .commit_value(commit_value)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic check_reg(input logic [lc3b_isa_pkg::reg_idx_width-1:0] got,
		input logic [lc3b_isa_pkg::reg_idx_width-1:0] expected, input string what);
		if (got !== expected)
			abort_run($sformatf("mismatch at time %0t: %s got %0d expected %0d",
				$time, what, got, expected));
	endtask

	task automatic check_word(input logic [lc3b_isa_pkg::word_width-1:0] got,
		input logic [lc3b_isa_pkg::word_width-1:0] expected, input string what);
		if (got !== expected)
			abort_run($sformatf("mismatch at time %0t: %s got %h expected %h",
				$time, what, got, expected));
	endtask

	task automatic check_bit(input logic got, input logic expected, input string what);
		if (got !== expected)
			abort_run($sformatf("mismatch at time %0t: %s got %b expected %b",
				$time, what, got, expected));
	endtask

	// Random legal instruction, optionally reading the previous destination
	function automatic logic [15:0] make_instr(input logic dep, input logic [2:0] prev);
		lc3b_isa_pkg::lc3b_opcode op;
		logic [15:0] w;
		logic [2:0] dr;
		logic [2:0] s1;
		logic [2:0] s2;
		w = 16'($urandom);
		dr = 3'($urandom);
		s1 = dep ? prev : w[8:6];
		s2 = (dep && w[15]) ? prev : w[2:0];
		case ($urandom % 4)
			0: op = lc3b_isa_pkg::op_add;
			1: op = lc3b_isa_pkg::op_and;
			2: op = lc3b_isa_pkg::op_not;
			default: op = lc3b_isa_pkg::op_lea;
		endcase
		case (op)
			lc3b_isa_pkg::op_not: return {op, dr, s1, 6'h3f};
			lc3b_isa_pkg::op_lea: return {op, dr, w[8:0]};
			default: return w[5] ? {op, dr, s1, 1'b1, w[4:0]} : {op, dr, s1, 3'b000, s2};
		endcase
	endfunction

	// Executes one accepted instruction in program order
	task automatic run_model(input logic [15:0] w, input logic [15:0] pc);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		a = model_regs[w[8:6]];
		b = w[5] ? {{11{w[4]}}, w[4:0]} : model_regs[w[2:0]];
		case (w[15:12])
			4'b0001: res = a + b; // ADD
			4'b0101: res = a & b; // AND
			4'b1001: res = ~a; // NOT
			default: res = pc + {{6{w[8]}}, w[8:0], 1'b0}; // LEA
		endcase
		model_regs[w[11:9]] = res;
		exp_reg.push_back(w[11:9]);
		exp_value.push_back(res);
	endtask

	initial
	begin
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= cycle_limit)
				abort_run($sformatf("timeout: run not finished after %0d cycles", cycle_limit));
		end
	end

	initial
	begin
		int sent;
		int in_flight;
		int gap;
		int mode;
		int mode_left;
		logic took;
		logic [2:0] last_dest;
		logic [15:0] pc;
		rst = 1'b1;
		instr = '0;
		instr_pc = '0;
		instr_valid = 1'b0;
		void'($urandom(32'h71d01b49));
		for (int i = 0; i < lc3b_isa_pkg::reg_count; i++)
			model_regs[i] = '0;
		sent = 0;
		in_flight = 0;
		gap = 0;
		mode = 0;
		mode_left = 0;
		last_dest = '0;
		pc = 16'($urandom) & 16'hfffe;
		@(posedge clk);
		@(negedge clk);
		if (commit_valid !== 1'b0)
			abort_run("commit_valid was not low during reset");
		@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (sent < n_instr || exp_reg.size() != 0)
		begin
			if (!instr_valid && sent < n_instr)
			begin
				if (gap > 0)
					gap--;
				else
				begin
					if (mode_left == 0)
					begin
						mode = $urandom % 3; // 0 gaps, 1 dependency burst, 2 valid held high
						mode_left = 4 + $urandom % 12;
					end
					mode_left--;
					pc = pc + 16'd2;
					instr = make_instr(mode == 1, last_dest);
					instr_pc = pc;
					instr_valid = 1'b1;
					last_dest = instr[11:9];
				end
			end
			#1;
			in_flight = exp_reg.size(); // Same as the ROB occupancy this cycle
			if (commit_valid)
			begin
				if (exp_reg.size() == 0)
					abort_run("commit seen with no instruction outstanding");
				check_reg(commit_reg, exp_reg.pop_front(), "commit register");
				check_word(commit_value, exp_value.pop_front(), "commit value");
			end
			// LEA waits only on a full ROB, an empty machine takes anything
			if (instr_valid && (in_flight == 0 || instr[15:12] == lc3b_isa_pkg::op_lea))
				check_bit(instr_ready, in_flight < ooo_pkg::rob_depth, "instr_ready");
			took = instr_valid && instr_ready;
			if (took)
			begin
				run_model(instr, instr_pc);
				sent++;
			end
			@(negedge clk);
			if (took)
			begin
				instr_valid = 1'b0;
				gap = (mode == 2) ? 0 : (mode == 1) ? $urandom % 2 : $urandom % 4;
			end
		end
		// No duplicate retirements once drained
		repeat (8)
		begin
			#1;
			if (commit_valid)
				abort_run("extra commit after all instructions retired");
			@(negedge clk);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* files.f */
hdl/lc3b_isa_pkg.sv
hdl/ooo_pkg.sv
hdl/issue_control.sv
hdl/alu_station.sv
hdl/reorder_buffer.sv
hdl/register_file.sv
hdl/ooo_core.sv
tests/ooo_core_chk.sv
tests/ooo_core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - hdl/lc3b_isa_pkg.sv
  - hdl/ooo_pkg.sv
  - hdl/issue_control.sv
  - hdl/alu_station.sv
  - hdl/reorder_buffer.sv
  - hdl/register_file.sv
  - hdl/ooo_core.sv
  - target: test
    files:
      - tests/ooo_core_chk.sv
      - tests/ooo_core_tb.sv
